/* Makefile */
# Verilator build and run for the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_frv_dispatch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/frv_dispatch_top.sv */
// Dispatch subsystem top joining the dispatch stage to the backend ports
`default_nettype none

module frv_dispatch_top import frv_pkg::*; (
    input  logic                  g_clk,         // Core clock
    input  logic                  arst_n,        // Async reset, active low

    // Decode side
    output logic                  s2_p_busy,
    input  logic                  s2_p_valid,
    input  logic [REG_ADDR_W-1:0] s2_rd,
    input  logic [REG_ADDR_W-1:0] s2_rs1,
    input  logic [REG_ADDR_W-1:0] s2_rs2,
    input  logic [XL:0]           s2_imm,
    input  logic [XL:0]           s2_pc,
    input  logic [4:0]            s2_uop,
    input  logic [4:0]            s2_fu,
    input  logic                  s2_trap,
    input  logic [OPR_SRC_W-1:0]  s2_opr_src,    // One-hot operand sources
    input  logic [1:0]            s2_size,
    input  logic [31:0]           s2_instr,

    input  logic                  flush,

    // Forwarding buses
    input  logic [REG_ADDR_W-1:0] fwd_s3_rd,
    input  logic [XL:0]           fwd_s3_wdata,
    input  logic                  fwd_s3_load,
    input  logic                  fwd_s3_csr,
    input  logic [REG_ADDR_W-1:0] fwd_s4_rd,
    input  logic [XL:0]           fwd_s4_wdata,
    input  logic                  fwd_s4_load,
    input  logic                  fwd_s4_csr,

    // Writeback into the GPRs
    input  logic                  gpr_wen,
    input  logic [REG_ADDR_W-1:0] gpr_rd,
    input  logic [XL:0]           gpr_wdata,

    // Execute side
    output logic [REG_ADDR_W-1:0] s3_rd,
    output logic [XL:0]           s3_opr_a,
    output logic [XL:0]           s3_opr_b,
    output logic [XL:0]           s3_opr_c,
    output logic [XL:0]           s3_pc,
    output logic [4:0]            s3_uop,
    output logic [4:0]            s3_fu,
    output logic                  s3_trap,
    output logic [1:0]            s3_size,
    output logic [31:0]           s3_instr,
    input  logic                  s3_p_busy,
    output logic                  s3_p_valid
);

    // Single stage with no extra latency at this level
    frv_pipeline_dispatch i_dispatch (
        .g_clk        (g_clk),
        .arst_n       (arst_n),
        .s2_p_busy    (s2_p_busy),
        .s2_p_valid   (s2_p_valid),
        .s2_rd        (s2_rd),
        .s2_rs1       (s2_rs1),
        .s2_rs2       (s2_rs2),
        .s2_imm       (s2_imm),
        .s2_pc        (s2_pc),
        .s2_uop       (s2_uop),
        .s2_fu        (s2_fu),
        .s2_trap      (s2_trap),
        .s2_opr_src   (s2_opr_src),
        .s2_size      (s2_size),
        .s2_instr     (s2_instr),
        .flush        (flush),
        .fwd_s3_rd    (fwd_s3_rd),
        .fwd_s3_wdata (fwd_s3_wdata),
        .fwd_s3_load  (fwd_s3_load),
        .fwd_s3_csr   (fwd_s3_csr),
        .fwd_s4_rd    (fwd_s4_rd),
        .fwd_s4_wdata (fwd_s4_wdata),
        .fwd_s4_load  (fwd_s4_load),
        .fwd_s4_csr   (fwd_s4_csr),
        .gpr_wen      (gpr_wen),
        .gpr_rd       (gpr_rd),
        .gpr_wdata    (gpr_wdata),
        .s3_rd        (s3_rd),
        .s3_opr_a     (s3_opr_a),
        .s3_opr_b     (s3_opr_b),
        .s3_opr_c     (s3_opr_c),
        .s3_pc        (s3_pc),
        .s3_uop       (s3_uop),
        .s3_fu        (s3_fu),
        .s3_trap      (s3_trap),
        .s3_size      (s3_size),
        .s3_instr     (s3_instr),
        .s3_p_busy    (s3_p_busy),
        .s3_p_valid   (s3_p_valid)
    );

endmodule

`default_nettype wire

/* rtl/frv_gprs.sv */
// General purpose register file with two combinational reads, one write and x0 reading zero
`default_nettype none

module frv_gprs import frv_pkg::*; (
    input  logic                  g_clk,     // Core clock
    input  logic                  arst_n,    // Async reset, active low
    input  logic [REG_ADDR_W-1:0] rs1_addr,  // Read port 1 address
    output logic [XL:0]           rs1_data,  // Read port 1 data
    input  logic [REG_ADDR_W-1:0] rs2_addr,  // Read port 2 address
    output logic [XL:0]           rs2_data,  // Read port 2 data
    input  logic                  rd_wen,    // Write enable
    input  logic [REG_ADDR_W-1:0] rd_addr,   // Write address
    input  logic [XL:0]           rd_data    // Write data
);

    localparam int NREGS = 1 << REG_ADDR_W;  // 32 architectural registers

    logic [XL:0] regs [NREGS-1:1];           // Storage only for x1..x31

    // Write port
    // ----------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;               // Architectural state starts at zero
            end
        end else if (rd_wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;        // Writes to x0 dropped
        end
    end

    // Read ports
    // ----------------------------------------
    // No write-to-read bypass so a write lands on the next edge
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 hardwired
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr]; // x0 hardwired

endmodule

`default_nettype wire

/* rtl/frv_pipeline_dispatch.sv */
// Dispatch stage with hazard bubbles, result forwarding, operand gathering and stage register
`default_nettype none

module frv_pipeline_dispatch import frv_pkg::*; (
    input  logic                  g_clk,         // Core clock
    input  logic                  arst_n,        // Async reset, active low

    // Decode side
    output logic                  s2_p_busy,     // Dispatch cannot accept
    input  logic                  s2_p_valid,    // Decoded instruction valid
    input  logic [REG_ADDR_W-1:0] s2_rd,         // Destination register
    input  logic [REG_ADDR_W-1:0] s2_rs1,        // Source register 1
    input  logic [REG_ADDR_W-1:0] s2_rs2,        // Source register 2
    input  logic [XL:0]           s2_imm,        // Decoded immediate
    input  logic [XL:0]           s2_pc,         // Program counter
    input  logic [4:0]            s2_uop,        // Micro-op code
    input  logic [4:0]            s2_fu,         // Functional unit
    input  logic                  s2_trap,       // Raise a trap
    input  logic [OPR_SRC_W-1:0]  s2_opr_src,    // One-hot operand sources
    input  logic [1:0]            s2_size,       // Instruction size
    input  logic [31:0]           s2_instr,      // Instruction word

    input  logic                  flush,         // Kill the stage register

    // Forwarding from execute
    input  logic [REG_ADDR_W-1:0] fwd_s3_rd,     // Execute destination
    input  logic [XL:0]           fwd_s3_wdata,  // Execute result
    input  logic                  fwd_s3_load,   // Execute holds a load
    input  logic                  fwd_s3_csr,    // Execute holds a CSR op

    // Forwarding from writeback
    input  logic [REG_ADDR_W-1:0] fwd_s4_rd,     // Writeback destination
    input  logic [XL:0]           fwd_s4_wdata,  // Writeback result
    input  logic                  fwd_s4_load,   // Writeback holds a load
    input  logic                  fwd_s4_csr,    // Writeback holds a CSR op

    // GPR write port
    input  logic                  gpr_wen,       // Write enable
    input  logic [REG_ADDR_W-1:0] gpr_rd,        // Write address
    input  logic [XL:0]           gpr_wdata,     // Write data

    // Execute side
    output logic [REG_ADDR_W-1:0] s3_rd,         // Destination register
    output logic [XL:0]           s3_opr_a,      // Operand A
    output logic [XL:0]           s3_opr_b,      // Operand B
    output logic [XL:0]           s3_opr_c,      // Operand C
    output logic [XL:0]           s3_pc,         // Program counter
    output logic [4:0]            s3_uop,        // Micro-op code
    output logic [4:0]            s3_fu,         // Functional unit
    output logic                  s3_trap,       // Raise a trap
    output logic [1:0]            s3_size,       // Instruction size
    output logic [31:0]           s3_instr,      // Instruction word
    input  logic                  s3_p_busy,     // Execute stalled
    output logic                  s3_p_valid     // Output valid
);

    logic [XL:0] gpr_rs1;                        // Raw register file reads
    logic [XL:0] gpr_rs2;
    logic [XL:0] dis_rs1;                        // Values after forwarding
    logic [XL:0] dis_rs2;
    logic [XL:0] pc_plus_imm;                    // Branch or AUIPC sum
    logic [XL:0] csr_addr;                       // CSR number, zero-extended
    logic [XL:0] csr_imm;                        // uimm from rs1 field
    logic [XL:0] opr_a;
    logic [XL:0] opr_b;
    logic [XL:0] opr_c;
    logic        s3_hit;                         // A source matches execute rd
    logic        s4_hit;                         // A source matches writeback rd
    logic        dis_bubble;                     // Unforwardable hazard
    logic        p_busy;                         // Stage register full and stalled
    logic        p_valid;                        // Valid into stage register
    logic [DIS_REG_W-1:0] pipe_in;
    logic [DIS_REG_W-1:0] pipe_out;

    // Hazard detection
    // ----------------------------------------
    assign s3_hit = (s2_rs1 == fwd_s3_rd) || (s2_rs2 == fwd_s3_rd);
    assign s4_hit = (s2_rs1 == fwd_s4_rd) || (s2_rs2 == fwd_s4_rd);

    // Load data is final by writeback, so fwd_s4_load never stalls
    assign dis_bubble = ((fwd_s3_load || fwd_s3_csr) && s3_hit)
                     || (fwd_s4_csr && s4_hit);  // CSR result late

    assign s2_p_busy = dis_bubble || p_busy;    // Combinational back-pressure
    assign p_valid   = s2_p_valid && !dis_bubble; // Bubble loads an empty slot

    // Forwarding with youngest result first
    // ----------------------------------------
    assign dis_rs1 = ((s2_rs1 == fwd_s3_rd) && |s2_rs1) ? fwd_s3_wdata :
                     ((s2_rs1 == fwd_s4_rd) && |s2_rs1) ? fwd_s4_wdata :
                                                          gpr_rs1;
    assign dis_rs2 = ((s2_rs2 == fwd_s3_rd) && |s2_rs2) ? fwd_s3_wdata :
                     ((s2_rs2 == fwd_s4_rd) && |s2_rs2) ? fwd_s4_wdata :
                                                          gpr_rs2;

    // Derived operand values
    assign pc_plus_imm = s2_pc + s2_imm;
    assign csr_addr    = {{(XLEN-12){1'b0}}, s2_imm[11:0]};
    assign csr_imm     = {{(XLEN-REG_ADDR_W){1'b0}}, s2_rs1}; // Unsigned per ISA

    // Operand select as AND-OR over one-hot flags
    // ----------------------------------------
    assign opr_a = ({XLEN{s2_opr_src[DIS_OPRA_RS1]}}  & dis_rs1)
                 | ({XLEN{s2_opr_src[DIS_OPRA_PCIM]}} & pc_plus_imm)
                 | ({XLEN{s2_opr_src[DIS_OPRA_CSRI]}} & csr_imm);

    assign opr_b = ({XLEN{s2_opr_src[DIS_OPRB_RS2]}}  & dis_rs2)
                 | ({XLEN{s2_opr_src[DIS_OPRB_IMM]}}  & s2_imm);

    assign opr_c = ({XLEN{s2_opr_src[DIS_OPRC_RS2]}}  & dis_rs2)
                 | ({XLEN{s2_opr_src[DIS_OPRC_CSRA]}} & csr_addr)
                 | ({XLEN{s2_opr_src[DIS_OPRC_PCIM]}} & pc_plus_imm);

    // Register file and stage register
    // ----------------------------------------
    frv_gprs i_gprs (
        .g_clk    (g_clk),
        .arst_n   (arst_n),
        .rs1_addr (s2_rs1),
        .rs1_data (gpr_rs1),
        .rs2_addr (s2_rs2),
        .rs2_data (gpr_rs2),
        .rd_wen   (gpr_wen),
        .rd_addr  (gpr_rd),
        .rd_data  (gpr_wdata)
    );

    assign pipe_in = {s2_rd, s2_pc, s2_uop, s2_fu, s2_size, s2_instr,
                      opr_a, opr_b, opr_c, s2_trap};

    assign {s3_rd, s3_pc, s3_uop, s3_fu, s3_size, s3_instr,
            s3_opr_a, s3_opr_b, s3_opr_c, s3_trap} = pipe_out;

    frv_pipeline_register #(
        .RLEN (DIS_REG_W)
    ) i_dispatch_pipe_reg (
        .g_clk   (g_clk),
        .arst_n  (arst_n),
        .i_data  (pipe_in),
        .i_valid (p_valid),
        .o_busy  (p_busy),
        .flush   (flush),
        .o_data  (pipe_out),
        .o_valid (s3_p_valid),
        .i_busy  (s3_p_busy)
    );

endmodule

`default_nettype wire

/* rtl/frv_pipeline_register.sv */
// Valid/busy pipeline stage register with flush and one payload deep
`default_nettype none

module frv_pipeline_register #(
    parameter int RLEN = 32                  // Payload width
) (
    input  logic            g_clk,           // Core clock
    input  logic            arst_n,          // Async reset, active low

    // Upstream side
    input  logic [RLEN-1:0] i_data,          // Payload from stage N
    input  logic            i_valid,         // Payload is valid
    output logic            o_busy,          // Stage cannot take new data

    input  logic            flush,           // Kill stored entry

    // Downstream side
    output logic [RLEN-1:0] o_data,          // Payload for stage N+1
    output logic            o_valid,         // Stored entry is valid
    input  logic            i_busy           // Stage N+1 stalled
);

    logic [RLEN-1:0] data_q;                 // Stored payload
    logic            valid_q;                // Stored valid

    // Full with downstream stalled leaves nowhere for new data
    assign o_busy = valid_q && i_busy;       // No skid buffer

    // Valid bit
    // ----------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;                 // Flush beats a new load
        end else if (!o_busy) begin
            valid_q <= i_valid;              // Low i_valid leaves an empty slot
        end
    end

    // Payload
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!o_busy) begin
            data_q <= i_data;                // Held while valid and stalled
        end
    end

    assign o_data  = data_q;
    assign o_valid = valid_q;

endmodule

`default_nettype wire

/* rtl/frv_pkg.sv */
// Dispatch stage package with data widths, operand-source bit positions and register sizes
`default_nettype none

package frv_pkg;

    // Data path
    // ----------------------------------------
    localparam int XLEN       = 32;          // Machine word width
    localparam int XL         = XLEN - 1;    // Top bit index of a word
    localparam int REG_ADDR_W = 5;           // GPR address width

    // Operand-source flags
    // ----------------------------------------
    localparam int OPR_SRC_W     = 8;        // Width of the one-hot source byte

    // Operand A choices
    localparam int DIS_OPRA_RS1  = 0;        // Forwarded rs1 value
    localparam int DIS_OPRA_PCIM = 1;        // PC plus immediate
    localparam int DIS_OPRA_CSRI = 2;        // Zero-extended CSR immediate

    // Operand B choices
    localparam int DIS_OPRB_RS2  = 3;        // Forwarded rs2 value
    localparam int DIS_OPRB_IMM  = 4;        // Decoded immediate

    // Operand C choices
    localparam int DIS_OPRC_RS2  = 5;        // Forwarded rs2 value as store data
    localparam int DIS_OPRC_CSRA = 6;        // CSR address from imm[11:0]
    localparam int DIS_OPRC_PCIM = 7;        // PC plus immediate as branch target

    // Stage register payload
    // ----------------------------------------
    // 178 bits of rd, pc, uop, fu, size, instr, three operands and trap
    localparam int DIS_REG_W = REG_ADDR_W    // rd
                             + XLEN          // pc
                             + 5             // uop
                             + 5             // fu
                             + 2             // size
                             + 32            // instr
                             + 3 * XLEN      // opr_a, opr_b, opr_c
                             + 1;            // trap

endpackage

`default_nettype wire

/* verification/dispatch_testdata.txt */
// num kind rd rs1 rs2 imm pc opr_src s3_rd s3_wdata s3_flg s4_rd s4_wdata s4_flg (all hex)
// exp_a exp_b exp_c exp_valid exp_busy; kind 0 wr 1 disp 2 fwd 3 flush 4 stall ff end
// flg bit0 load, bit1 csr; kind 0 writes imm into register rd
01 1 05 01 02 0 00000100 29 00 0 0 00 0 0 0 0 0 1 0
02 0 01 00 00 11111111 0 00 00 0 0 00 0 0 0 0 0 0 0
03 0 02 00 00 22222222 0 00 00 0 0 00 0 0 0 0 0 0 0
04 0 03 00 00 a5a5a5a5 0 00 00 0 0 00 0 0 0 0 0 0 0
05 1 06 01 02 0 00000104 29 00 0 0 00 0 0 11111111 22222222 22222222 1 0
06 1 07 03 00 00000800 00000108 11 00 0 0 00 0 0 a5a5a5a5 00000800 0 1 0
07 1 08 00 00 00000024 00001000 92 00 0 0 00 0 0 00001024 00000024 00001024 1 0
08 1 09 1f 00 fffff305 0000010c 44 00 0 0 00 0 0 0000001f 0 00000305 1 0
09 1 0a 01 02 0 00000110 00 00 0 0 00 0 0 0 0 0 1 0
0a 2 0b 01 02 0 00000114 29 01 cafe0001 0 01 beef0001 0 cafe0001 22222222 22222222 1 0
0b 2 0c 01 02 0 00000118 29 05 cafe0005 0 02 beef0002 0 11111111 beef0002 beef0002 1 0
0c 2 0d 00 00 0 0000011c 29 00 dead0003 0 00 dead0004 0 0 0 0 1 0
0d 2 0e 03 02 0 00000120 29 00 0 0 03 0badf00d 1 0badf00d 22222222 22222222 1 0
0e 2 0f 01 02 0 00000124 29 04 12345678 1 00 0 0 11111111 22222222 22222222 1 0
0f 4 10 01 02 0 00000128 29 01 0 1 00 0 0 0 0 0 0 1
10 4 11 01 02 0 0000012c 29 02 0 2 00 0 0 0 0 0 0 1
11 4 12 01 02 0 00000130 29 00 0 0 01 0 2 0 0 0 0 1
12 0 04 00 00 44444444 0 00 00 0 0 00 0 0 0 0 0 0 0
13 1 13 04 03 0 00000134 29 00 0 0 00 0 0 44444444 a5a5a5a5 a5a5a5a5 1 0
14 0 00 00 00 ffffffff 0 00 00 0 0 00 0 0 0 0 0 0 0
15 1 14 00 04 0 00000138 29 00 0 0 00 0 0 0 44444444 44444444 1 0
16 3 15 01 02 0 0000013c 29 00 0 0 00 0 0 11111111 22222222 22222222 0 0
17 1 16 02 01 0 00000140 29 00 0 0 00 0 0 22222222 11111111 11111111 1 0
18 2 17 03 04 0 00000144 29 04 0000abcd 0 03 00005555 1 00005555 0000abcd 0000abcd 1 0
00 ff 00 00 00 0 0 00 00 0 0 00 0 0 0 0 0 0 0

/* verification/tb_frv_dispatch.sv */
// Dispatch subsystem testbench driving file vectors cross-checked against a GPR model
`default_nettype none

module tb_frv_dispatch;

    localparam int    CLK_PERIOD = 40;
    localparam int    DRIVE_DLY  = 2;            // Input skew after rising edge
    localparam int    TIMEOUT    = 50;           // Cycles allowed per wait loop
    localparam int    NF         = 19;           // Words per vector line
    localparam int    MAX_VEC    = 64;
    localparam string DATA_FILE  = "verification/dispatch_testdata.txt";

    logic        g_clk;
    logic        arst_n;
    logic        s2_p_valid, s2_trap, flush, s3_p_busy, gpr_wen;
    logic        fwd_s3_load, fwd_s3_csr, fwd_s4_load, fwd_s4_csr;
    logic [4:0]  s2_rd, s2_rs1, s2_rs2, s2_uop, s2_fu, fwd_s3_rd, fwd_s4_rd, gpr_rd;
    logic [31:0] s2_imm, s2_pc, s2_instr, fwd_s3_wdata, fwd_s4_wdata, gpr_wdata;
    logic [7:0]  s2_opr_src;
    logic [1:0]  s2_size;
    logic        s2_p_busy, s3_p_valid, s3_trap;
    logic [4:0]  s3_rd, s3_uop, s3_fu;
    logic [31:0] s3_opr_a, s3_opr_b, s3_opr_c, s3_pc, s3_instr;
    logic [1:0]  s3_size;

    logic [31:0] vec [NF*MAX_VEC];               // Flat word image of the data file
    logic [31:0] model_regs [32];                // Reference GPR contents
    logic [31:0] lcg_state;
    logic        busy_force;                     // Pins execute busy high
    logic        timed_out;
    int          errors;
    int          tests_run;
    int          tests_bad;

    frv_dispatch_top dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD/2) g_clk = ~g_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Random execute back-pressure
    initial begin
        s3_p_busy = 1'b0;
        lcg_state = 32'd1;                       // Seed
        forever begin
            @(posedge g_clk);
            #DRIVE_DLY;
            lcg_state = lcg_next(lcg_state);
            s3_p_busy = arst_n && (busy_force || lcg_state[16]);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic string kind_name(input logic [31:0] kind);
        case (kind)
            32'd0:   return "reg write";
            32'd1:   return "dispatch";
            32'd2:   return "forward";
            32'd3:   return "flush";
            32'd4:   return "stall";
            default: return "unknown";
        endcase
    endfunction

    // Reference model
    // ----------------------------------------
    function automatic logic [31:0] fwd_value(input logic [4:0] addr);
        if (addr == 5'd0) return 32'd0;                     // x0 never forwarded
        else if (addr == fwd_s3_rd) return fwd_s3_wdata;    // Youngest first
        else if (addr == fwd_s4_rd) return fwd_s4_wdata;
        else return model_regs[addr];
    endfunction

    task automatic model_operands(output logic [31:0] a, output logic [31:0] b,
                                  output logic [31:0] c);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] pcim;
        r1   = fwd_value(s2_rs1);
        r2   = fwd_value(s2_rs2);
        pcim = s2_pc + s2_imm;
        a    = 32'd0;                            // No flag gives zero
        b    = 32'd0;
        c    = 32'd0;
        if (s2_opr_src[0]) a = a | r1;
        if (s2_opr_src[1]) a = a | pcim;
        if (s2_opr_src[2]) a = a | {27'd0, s2_rs1};         // uimm
        if (s2_opr_src[3]) b = b | r2;
        if (s2_opr_src[4]) b = b | s2_imm;
        if (s2_opr_src[5]) c = c | r2;
        if (s2_opr_src[6]) c = c | {20'd0, s2_imm[11:0]};   // CSR number
        if (s2_opr_src[7]) c = c | pcim;
    endtask

    task automatic cross_check(input int b);
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] ec;
        model_operands(ea, eb, ec);
        check_value("data file opr_a vs model", vec[b+14], ea);
        check_value("data file opr_b vs model", vec[b+15], eb);
        check_value("data file opr_c vs model", vec[b+16], ec);
    endtask

    // Stimulus
    // ----------------------------------------
    task automatic clear_forwarding();
        fwd_s3_rd    = 5'd0;
        fwd_s3_wdata = 32'd0;
        fwd_s3_load  = 1'b0;
        fwd_s3_csr   = 1'b0;
        fwd_s4_rd    = 5'd0;
        fwd_s4_wdata = 32'd0;
        fwd_s4_load  = 1'b0;
        fwd_s4_csr   = 1'b0;
    endtask

    task automatic drive_vector(input int b);
        s2_rd        = vec[b+2][4:0];
        s2_rs1       = vec[b+3][4:0];
        s2_rs2       = vec[b+4][4:0];
        s2_imm       = vec[b+5];
        s2_pc        = vec[b+6];
        s2_opr_src   = vec[b+7][7:0];
        fwd_s3_rd    = vec[b+8][4:0];
        fwd_s3_wdata = vec[b+9];
        fwd_s3_load  = vec[b+10][0];
        fwd_s3_csr   = vec[b+10][1];
        fwd_s4_rd    = vec[b+11][4:0];
        fwd_s4_wdata = vec[b+12];
        fwd_s4_load  = vec[b+13][0];
        fwd_s4_csr   = vec[b+13][1];
        s2_uop       = vec[b][4:0];              // Test number tags passthrough fields
        s2_fu        = vec[b+1][4:0];
        s2_trap      = vec[b][0];
        s2_size      = vec[b][1:0];
        s2_instr     = 32'h13 + vec[b];
    endtask

    task automatic check_outputs(input int b);
        check_value("s3_opr_a", s3_opr_a, vec[b+14]);
        check_value("s3_opr_b", s3_opr_b, vec[b+15]);
        check_value("s3_opr_c", s3_opr_c, vec[b+16]);
        check_value("s3_rd", 32'(s3_rd), vec[b+2] & 32'h1f);
        check_value("s3_pc", s3_pc, vec[b+6]);
        check_value("s3_instr", s3_instr, 32'h13 + vec[b]);
        check_value("s3_uop", 32'(s3_uop), vec[b] & 32'h1f);
        check_value("s3_fu", 32'(s3_fu), vec[b+1] & 32'h1f);
        check_value("s3_size", 32'(s3_size), vec[b] & 32'h3);
        check_value("s3_trap", 32'(s3_trap), vec[b] & 32'h1);
    endtask

    // Hold the instruction until dispatch takes it
    task automatic wait_accept(input int b);
        int n;
        n = 0;
        @(negedge g_clk);
        check_value("s2_p_busy", 32'(s2_p_busy), vec[b+18]);
        while (s2_p_busy && n < TIMEOUT) begin
            @(negedge g_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timeout: dispatch never accepted the instruction of test %0d", vec[b]);
            timed_out = 1'b1;
        end
        @(posedge g_clk);                        // Accepting edge
        #DRIVE_DLY;
        s2_p_valid = 1'b0;
        clear_forwarding();
    endtask

    // Follow the output through back-pressure until execute takes it
    task automatic wait_output(input int b);
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        @(negedge g_clk);                        // One cycle after accept
        while (s3_p_valid && !taken && n < TIMEOUT) begin
            check_outputs(b);                    // Also proves outputs hold while stalled
            if (s3_p_busy) begin
                check_value("s2_p_busy", 32'(s2_p_busy), 32'd1);
                @(negedge g_clk);
                n++;
            end else begin
                taken = 1'b1;
            end
        end
        if (n >= TIMEOUT) begin
            $display("Timeout: execute never took the output of test %0d", vec[b]);
            timed_out = 1'b1;
        end else if (!taken) begin
            check_value("s3_p_valid", 32'(s3_p_valid), 32'd1); // Missing or lost while stalled
        end else begin
            @(negedge g_clk);
            check_value("s3_p_valid", 32'(s3_p_valid), 32'd0); // Output exactly once
        end
    endtask

    // Vector kinds
    // ----------------------------------------
    task automatic do_write(input int b);
        @(posedge g_clk);
        #DRIVE_DLY;
        gpr_wen   = 1'b1;
        gpr_rd    = vec[b+2][4:0];
        gpr_wdata = vec[b+5];
        if (vec[b+2][4:0] != 5'd0) model_regs[vec[b+2][4:0]] = vec[b+5];
        @(posedge g_clk);
        #DRIVE_DLY;
        gpr_wen = 1'b0;
        @(negedge g_clk);
    endtask

    task automatic do_dispatch(input int b);
        @(posedge g_clk);
        #DRIVE_DLY;
        drive_vector(b);
        s2_p_valid = 1'b1;
        cross_check(b);
        wait_accept(b);
        if (!timed_out) wait_output(b);
    endtask

    task automatic do_flush(input int b);
        busy_force = 1'b1;                       // Park the entry in the stage register
        @(posedge g_clk);
        #DRIVE_DLY;
        drive_vector(b);
        s2_p_valid = 1'b1;
        cross_check(b);
        wait_accept(b);
        flush = 1'b1;
        @(negedge g_clk);
        check_value("s3_p_valid", 32'(s3_p_valid), 32'd1);   // Pending before flush
        check_outputs(b);
        @(posedge g_clk);
        #DRIVE_DLY;
        flush = 1'b0;
        @(negedge g_clk);
        check_value("s3_p_valid", 32'(s3_p_valid), vec[b+17]);
        busy_force = 1'b0;
    endtask

    task automatic do_stall(input int b);
        @(posedge g_clk);
        #DRIVE_DLY;
        drive_vector(b);
        s2_p_valid = 1'b1;
        @(negedge g_clk);
        check_value("s2_p_busy", 32'(s2_p_busy), vec[b+18]);
        @(posedge g_clk);                        // Bubble enters the stage register
        #DRIVE_DLY;
        s2_p_valid = 1'b0;
        clear_forwarding();
        @(negedge g_clk);
        check_value("s3_p_valid", 32'(s3_p_valid), vec[b+17]);
    endtask

    // Main sequence
    // ----------------------------------------
    initial begin
        int b;
        int err_before;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        timed_out  = 1'b0;
        busy_force = 1'b0;
        arst_n     = 1'b0;
        s2_p_valid = 1'b0;
        flush      = 1'b0;
        gpr_wen    = 1'b0;
        gpr_rd     = 5'd0;
        gpr_wdata  = 32'd0;
        $readmemh(DATA_FILE, vec);
        drive_vector(0);                         // Harmless fields until the first test
        clear_forwarding();
        for (int r = 0; r < 32; r++) model_regs[r] = 32'd0;
        repeat (3) @(posedge g_clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        @(negedge g_clk);
        err_before = errors;
        check_value("s3_p_valid", 32'(s3_p_valid), 32'd0);
        tests_run++;
        if (errors != err_before) tests_bad++;
        $display("test reset: %s", (errors == err_before) ? "ok" : "has errors");

        for (int i = 0; i < MAX_VEC && !timed_out; i++) begin
            b = i * NF;
            if (vec[b+1] == 32'hff) break;       // End marker
            err_before = errors;
            case (vec[b+1])
                32'd0:        do_write(b);
                32'd1, 32'd2: do_dispatch(b);
                32'd3:        do_flush(b);
                32'd4:        do_stall(b);
                default: begin
                    $display("Unknown vector kind %0h in test %0d", vec[b+1], vec[b]);
                    errors++;
                end
            endcase
            tests_run++;
            if (errors != err_before || timed_out) tests_bad++;
            $display("test %0d (%s): %s", vec[b], kind_name(vec[b+1]),
                     (errors == err_before && !timed_out) ? "ok" : "has errors");
        end

        if (tests_run < 2) begin
            $display("No vectors were read from %s", DATA_FILE);
            errors++;
        end
        $display("Tests run %0d, with errors %0d, failed checks %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/frv_pkg.sv
rtl/frv_gprs.sv
rtl/frv_pipeline_register.sv
rtl/frv_pipeline_dispatch.sv
rtl/frv_dispatch_top.sv
verification/tb_frv_dispatch.sv
